//--- usb_cdr_golden.txt
# Lane periods p0 p1 p2 p3 in ref_clk cycles (0 is a silent line), step length, loss_clear
# request, then the expected locked_mask and loss_flags in hex
20 40 6 0 300 0 1 0
20 16 24 28 300 0 f 0
20 16 24 28 200 0 f 0
0 16 24 28 300 0 e 1
20 16 24 28 300 0 f 1
20 16 24 28 200 1 f 0
20 0 24 0 300 0 5 a
20 0 24 0 300 1 5 0
0 16 0 28 300 1 a 5
40 16 6 28 300 0 a 5
12 16 30 28 300 1 f 0
0 0 30 28 300 0 c 3
11 31 30 28 300 1 c 0
0 0 0 0 300 0 0 c
20 20 20 20 300 1 f 0

//--- sim.f
+incdir+.
usb_cdr_pkg.sv
usb_line_edge_detect.sv
usb_clock_recovery.sv
usb_lock_monitor.sv
usb_cdr_array.sv
tb_usb_cdr_array.sv

//--- Bender.yml
package:
  name: usb_cdr_array

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - usb_cdr_pkg.sv
      - usb_line_edge_detect.sv
      - usb_clock_recovery.sv
      - usb_lock_monitor.sv
      - usb_cdr_array.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_usb_cdr_array.sv

//--- tb_usb_cdr_array.sv
// Testbench for the four-lane USB clock-recovery array, driven by a golden step file
`timescale 1ns/1ps
`include "usb_cdr_consts.svh"

module tb_usb_cdr_array;

    import usb_cdr_pkg::*;

    localparam int WIN_CYCLES = 100;

    // One line of the golden file
    typedef struct packed {
        logic [`USB_CDR_LANES-1:0][7:0] period;
        logic [15:0]                    dur;
        logic                           clr;
        lane_mask_t                     exp_locked;
        lane_mask_t                     exp_loss;
    } golden_step_t;

    logic        ref_clk = 1'b0;
    logic        rst_n;
    lane_line_t  line_in [`USB_CDR_LANES];
    logic        loss_clear;
    lane_mask_t  rec_clk;
    lane_mask_t  locked_mask;
    lane_count_t lock_count;
    logic        all_locked;
    lane_mask_t  loss_flags;

    golden_step_t steps [$];
    integer       seed        = 32'h253c_fd13;
    int           err_count   = 0;
    int           check_count = 0;
    int           cycle_count = 0;
    int           cycle_limit = 0;

    // Line generator state per lane
    int         phase    [`USB_CDR_LANES];
    int         period   [`USB_CDR_LANES];
    lane_line_t act_enc  [`USB_CDR_LANES];
    lane_line_t idle_enc [`USB_CDR_LANES];

    // Recovered clock statistics over the closing window of a step
    int         rise_cnt  [`USB_CDR_LANES];
    int         start_cnt [`USB_CDR_LANES];
    lane_mask_t clk_prev;
    lane_mask_t clk_seen;

    usb_cdr_array DUT (
        .ref_clk     (ref_clk),
        .rst_n       (rst_n),
        .line_in     (line_in),
        .loss_clear  (loss_clear),
        .rec_clk     (rec_clk),
        .locked_mask (locked_mask),
        .lock_count  (lock_count),
        .all_locked  (all_locked),
        .loss_flags  (loss_flags)
    );

    always #20 ref_clk = ~ref_clk;

    // Run limit from the summed step lengths
    always @(posedge ref_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("ERROR: run did not finish within %0d cycles", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    function automatic int count_bits(input lane_mask_t m);
        int n;
        n = 0;
        for (int i = 0; i < `USB_CDR_LANES; i++) begin
            n += m[i];
        end
        return n;
    endfunction

    task automatic load_golden();
        int                 fd;
        int                 n;
        int                 total;
        int                 pv [4];
        int                 dur;
        int                 clr;
        logic [31:0]        lk;
        logic [31:0]        ls;
        logic [8*160-1:0]   line_buf;
        golden_step_t       st;
        total = 0;
        fd = $fopen("usb_cdr_golden.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open the golden file usb_cdr_golden.txt");
            err_count++;
        end else begin
            while (!$feof(fd)) begin
                line_buf = '0;
                n = $fgets(line_buf, fd);
                n = $sscanf(line_buf, "%d %d %d %d %d %d %h %h",
                            pv[0], pv[1], pv[2], pv[3], dur, clr, lk, ls);
                // Comment and blank lines scan nothing
                if (n == 8) begin
                    for (int i = 0; i < `USB_CDR_LANES; i++) begin
                        st.period[i] = 8'(pv[i]);
                    end
                    st.dur        = 16'(dur);
                    st.clr        = clr[0];
                    st.exp_locked = lk[`USB_CDR_LANES-1:0];
                    st.exp_loss   = ls[`USB_CDR_LANES-1:0];
                    steps.push_back(st);
                    total += dur;
                end else if (n > 0) begin
                    $display("ERROR: golden file line %0d has a wrong field count",
                             steps.size() + 1);
                    err_count++;
                end
            end
            $fclose(fd);
            if (steps.size() == 0) begin
                $display("ERROR: golden file holds no test steps");
                err_count++;
            end
        end
        cycle_limit = total + 200;
    endtask

    task automatic sample_clocks(input bit in_win);
        for (int i = 0; i < `USB_CDR_LANES; i++) begin
            if (in_win) begin
                if (!clk_prev[i] && rec_clk[i]) begin
                    rise_cnt[i]++;
                end
                if (rec_clk[i]) begin
                    clk_seen[i] = 1'b1;
                end
            end
        end
        clk_prev = rec_clk;
    endtask

    // Active half has dp != dm, idle half has dp == dm, encodings drawn per period
    task automatic drive_lines(input bit in_win);
        for (int i = 0; i < `USB_CDR_LANES; i++) begin
            if (period[i] == 0) begin
                line_in[i] = idle_enc[i];
            end else begin
                if (phase[i] == 0) begin
                    act_enc[i]  = ($random(seed) & 1) ? 2'b10 : 2'b01;
                    idle_enc[i] = ($random(seed) & 1) ? 2'b11 : 2'b00;
                    if (in_win) begin
                        start_cnt[i]++;
                    end
                end
                line_in[i] = (phase[i] < period[i] / 2) ? act_enc[i] : idle_enc[i];
                phase[i]   = (phase[i] + 1) % period[i];
            end
        end
    endtask

    task automatic run_step(input golden_step_t st);
        int win_start;
        int new_p;
        win_start = int'(st.dur) - WIN_CYCLES;
        for (int i = 0; i < `USB_CDR_LANES; i++) begin
            new_p = st.period[i];
            if (new_p != period[i]) begin
                period[i] = new_p;
                phase[i]  = 0;
            end
            rise_cnt[i]  = 0;
            start_cnt[i] = 0;
        end
        clk_seen = '0;
        for (int c = 0; c < int'(st.dur); c++) begin
            @(negedge ref_clk);
            sample_clocks(c >= win_start);
            loss_clear = st.clr && (c == 0);
            drive_lines(c >= win_start);
        end
    endtask

    task automatic check_step(input int idx, input golden_step_t st);
        lane_count_t exp_count;
        logic        exp_all;
        int          diff;
        exp_count = lane_count_t'(count_bits(st.exp_locked));
        exp_all   = &st.exp_locked;
        check_count += 4;
        assert (locked_mask == st.exp_locked) else begin
            $display("FAIL t=%0t step %0d locked_mask expected %h got %h",
                     $time, idx, st.exp_locked, locked_mask);
            err_count++;
        end
        assert (lock_count == exp_count) else begin
            $display("FAIL t=%0t step %0d lock_count expected %0d got %0d",
                     $time, idx, exp_count, lock_count);
            err_count++;
        end
        assert (all_locked == exp_all) else begin
            $display("FAIL t=%0t step %0d all_locked expected %b got %b",
                     $time, idx, exp_all, all_locked);
            err_count++;
        end
        assert (loss_flags == st.exp_loss) else begin
            $display("FAIL t=%0t step %0d loss_flags expected %h got %h",
                     $time, idx, st.exp_loss, loss_flags);
            err_count++;
        end
        for (int i = 0; i < `USB_CDR_LANES; i++) begin
            check_count++;
            if (st.exp_locked[i]) begin
                // One recovered rising edge per line period, give or take the lag
                diff = rise_cnt[i] - start_cnt[i];
                assert (diff >= -1 && diff <= 1) else begin
                    $display("FAIL t=%0t step %0d rec_clk[%0d] rising edges expected %0d got %0d",
                             $time, idx, i, start_cnt[i], rise_cnt[i]);
                    err_count++;
                end
            end else begin
                assert (!clk_seen[i]) else begin
                    $display("FAIL t=%0t step %0d rec_clk[%0d] expected 0 got 1",
                             $time, idx, i);
                    err_count++;
                end
            end
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        loss_clear = 1'b0;
        clk_prev   = '0;
        clk_seen   = '0;
        for (int i = 0; i < `USB_CDR_LANES; i++) begin
            line_in[i]  = 2'b00;
            phase[i]    = 0;
            period[i]   = 0;
            act_enc[i]  = 2'b10;
            idle_enc[i] = 2'b00;
        end
        load_golden();
        repeat (3) @(negedge ref_clk);
        rst_n = 1'b1;
        for (int s = 0; s < steps.size(); s++) begin
            run_step(steps[s]);
            check_step(s + 1, steps[s]);
        end
        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- usb_cdr_array.sv
// USB four-lane receive clock-recovery front end with shared edge detection
`timescale 1ns/1ps
`include "usb_cdr_consts.svh"

module usb_cdr_array (
    input  logic                       ref_clk,
    input  logic                       rst_n,
    input  usb_cdr_pkg::lane_line_t    line_in [`USB_CDR_LANES],
    input  logic                       loss_clear,
    output usb_cdr_pkg::lane_mask_t    rec_clk,
    output usb_cdr_pkg::lane_mask_t    locked_mask,
    output usb_cdr_pkg::lane_count_t   lock_count,
    output logic                       all_locked,
    output usb_cdr_pkg::lane_mask_t    loss_flags
);

    import usb_cdr_pkg::*;

    lane_evt_t    lane_evt [`USB_CDR_LANES];
    lane_status_t status   [`USB_CDR_LANES];

    usb_line_edge_detect u_edge_detect (
        .ref_clk  (ref_clk),
        .rst_n    (rst_n),
        .line_in  (line_in),
        .lane_evt (lane_evt)
    );

    // One recovery block per lane
    for (genvar g = 0; g < `USB_CDR_LANES; g++) begin : g_lane
        usb_clock_recovery u_recovery (
            .ref_clk  (ref_clk),
            .rst_n    (rst_n),
            .lane_evt (lane_evt[g]),
            .status   (status[g])
        );
    end

    usb_lock_monitor u_monitor (
        .ref_clk     (ref_clk),
        .rst_n       (rst_n),
        .status      (status),
        .loss_clear  (loss_clear),
        .rec_clk     (rec_clk),
        .locked_mask (locked_mask),
        .lock_count  (lock_count),
        .all_locked  (all_locked),
        .loss_flags  (loss_flags)
    );

endmodule

//--- usb_lock_monitor.sv
// USB lock monitor collecting lane lock mask, lock count and sticky loss flags
`timescale 1ns/1ps
`include "usb_cdr_consts.svh"

module usb_lock_monitor (
    input  logic                       ref_clk,
    input  logic                       rst_n,
    input  usb_cdr_pkg::lane_status_t  status [`USB_CDR_LANES],
    input  logic                       loss_clear,
    output usb_cdr_pkg::lane_mask_t    rec_clk,
    output usb_cdr_pkg::lane_mask_t    locked_mask,
    output usb_cdr_pkg::lane_count_t   lock_count,
    output logic                       all_locked,
    output usb_cdr_pkg::lane_mask_t    loss_flags
);

    import usb_cdr_pkg::*;

    lane_mask_t  cur_locked;
    lane_mask_t  lock_fall;
    lane_count_t cur_count;

    // Gather the per-lane bits into masks
    always_comb begin
        cur_count = '0;
        for (int i = 0; i < `USB_CDR_LANES; i++) begin
            rec_clk[i]    = status[i].rec_clk;
            cur_locked[i] = status[i].locked;
            cur_count     = cur_count + lane_count_t'(status[i].locked);
        end
    end

    // Registered mask doubles as the previous lock state
    assign lock_fall = locked_mask & ~cur_locked;

    always_ff @(posedge ref_clk or negedge rst_n) begin
        if (!rst_n) begin
            locked_mask <= '0;
            lock_count  <= '0;
            all_locked  <= 1'b0;
        end else begin
            locked_mask <= cur_locked;
            lock_count  <= cur_count;
            all_locked  <= &cur_locked;
        end
    end

    // Fall wins over a clear in the same cycle
    always_ff @(posedge ref_clk or negedge rst_n) begin
        if (!rst_n) begin
            loss_flags <= '0;
        end else begin
            loss_flags <= (loss_flags & ~{`USB_CDR_LANES{loss_clear}}) | lock_fall;
        end
    end

    a_count_matches : assert property (
        @(posedge ref_clk) disable iff (!rst_n)
        lock_count == $countones(locked_mask)
    );

endmodule

//--- usb_clock_recovery.sv
// USB per-lane clock recovery with period measurement, lock tracking and clock rebuild
`timescale 1ns/1ps
`include "usb_cdr_consts.svh"

module usb_clock_recovery (
    input  logic                     ref_clk,
    input  logic                     rst_n,
    input  usb_cdr_pkg::lane_evt_t   lane_evt,
    output usb_cdr_pkg::lane_status_t status
);

    import usb_cdr_pkg::*;

    // Cycles since the last edge strobe, saturating
    period_t    count_q;
    // Edge interval captured when lock was taken
    period_t    div_q;
    period_t    half_div;
    cdr_state_e state_q;
    logic       rec_clk_q;
    logic       in_window;
    logic       silent;

    assign in_window = (count_q > `USB_CDR_LOCK_MIN) && (count_q < `USB_CDR_LOCK_MAX);
    assign silent    = (count_q > `USB_CDR_UNLOCK_LIMIT);
    assign half_div  = div_q >> 1;

    always_ff @(posedge ref_clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (lane_evt.edge_strobe) begin
            count_q <= '0;
        end else if (count_q != '1) begin
            count_q <= count_q + 1'b1;
        end
    end

    // Lock FSM
    always_ff @(posedge ref_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= HUNT;
        end else if (silent) begin
            state_q <= HUNT;
        end else if (lane_evt.edge_strobe && in_window) begin
            state_q <= TRACK;
        end
    end

    // Divider holds its last value outside TRACK
    always_ff @(posedge ref_clk or negedge rst_n) begin
        if (!rst_n) begin
            div_q <= '0;
        end else if (lane_evt.edge_strobe && in_window) begin
            div_q <= count_q;
        end
    end

    // Recovered clock
    always_ff @(posedge ref_clk or negedge rst_n) begin
        if (!rst_n) begin
            rec_clk_q <= 1'b0;
        end else if (silent) begin
            rec_clk_q <= 1'b0;
        end else if (lane_evt.edge_strobe) begin
            // Start high on every edge once locked, including the locking edge
            if (in_window || state_q == TRACK) begin
                rec_clk_q <= 1'b1;
            end
        end else if (state_q == TRACK && count_q == half_div) begin
            // Midpoint of the measured period
            rec_clk_q <= ~rec_clk_q;
        end
    end

    assign status.rec_clk = rec_clk_q;
    assign status.locked  = (state_q == TRACK);

    a_hunt_clk_low : assert property (
        @(posedge ref_clk) disable iff (!rst_n)
        (state_q == HUNT) |-> !rec_clk_q
    );

    a_track_div_ok : assert property (
        @(posedge ref_clk) disable iff (!rst_n)
        (state_q == TRACK) |->
            (div_q > `USB_CDR_LOCK_MIN) && (div_q < `USB_CDR_LOCK_MAX)
    );

    // Each strobe follows a rise of the activity level two cycles before
    a_strobe_after_rise : assert property (
        @(posedge ref_clk) disable iff (!rst_n)
        lane_evt.edge_strobe |-> $past(lane_evt.level, 2) && !$past(lane_evt.level, 3)
    );

endmodule

//--- usb_line_edge_detect.sv
// USB line front end that registers all lane pairs and strobes rising activity edges
`timescale 1ns/1ps
`include "usb_cdr_consts.svh"

module usb_line_edge_detect (
    input  logic                   ref_clk,
    input  logic                   rst_n,
    input  usb_cdr_pkg::lane_line_t line_in [`USB_CDR_LANES],
    output usb_cdr_pkg::lane_evt_t  lane_evt [`USB_CDR_LANES]
);

    import usb_cdr_pkg::*;

    // Differential activity, registered once from the pins
    lane_mask_t act_q;
    // Last two activity samples per lane, newest in bit 0
    logic [1:0] hist_q [`USB_CDR_LANES];
    lane_mask_t strobe_q;

    always_ff @(posedge ref_clk or negedge rst_n) begin
        if (!rst_n) begin
            act_q <= '0;
            for (int i = 0; i < `USB_CDR_LANES; i++) begin
                hist_q[i] <= 2'b00;
            end
        end else begin
            for (int i = 0; i < `USB_CDR_LANES; i++) begin
                act_q[i]  <= line_in[i].dp ^ line_in[i].dm;
                hist_q[i] <= {hist_q[i][0], act_q[i]};
            end
        end
    end

    // A 0 then 1 in the history marks a rising edge
    always_ff @(posedge ref_clk or negedge rst_n) begin
        if (!rst_n) begin
            strobe_q <= '0;
        end else begin
            for (int i = 0; i < `USB_CDR_LANES; i++) begin
                strobe_q[i] <= (hist_q[i] == 2'b01);
            end
        end
    end

    for (genvar g = 0; g < `USB_CDR_LANES; g++) begin : g_evt
        assign lane_evt[g].level       = act_q[g];
        assign lane_evt[g].edge_strobe = strobe_q[g];

        // Strobe is a single-cycle pulse per edge
        a_strobe_single : assert property (
            @(posedge ref_clk) disable iff (!rst_n)
            strobe_q[g] |=> !strobe_q[g]
        );
    end

endmodule

//--- usb_cdr_pkg.sv
// USB clock-recovery shared types for lane lines, edge events and lock status
`include "usb_cdr_consts.svh"

package usb_cdr_pkg;

    // Period counter value in ref_clk cycles
    typedef logic [`USB_CDR_PERIOD_W-1:0] period_t;

    // One bit per lane
    typedef logic [`USB_CDR_LANES-1:0] lane_mask_t;

    // Number of locked lanes, wide enough to hold the full lane count
    typedef logic [$clog2(`USB_CDR_LANES+1)-1:0] lane_count_t;

    // Raw D+/D- pair of one lane
    typedef struct packed {
        logic dp;
        logic dm;
    } lane_line_t;

    // Registered activity level and its rising-edge strobe
    typedef struct packed {
        logic level;
        logic edge_strobe;
    } lane_evt_t;

    typedef struct packed {
        logic rec_clk;
        logic locked;
    } lane_status_t;

    typedef enum logic {HUNT, TRACK} cdr_state_e;

endpackage

//--- usb_cdr_consts.svh
// USB clock-recovery constants for lane count, counter width and lock thresholds
`ifndef USB_CDR_CONSTS_SVH
`define USB_CDR_CONSTS_SVH

// Number of receive lanes
`define USB_CDR_LANES 4

// Width of the per-lane period counter in ref_clk cycles
`define USB_CDR_PERIOD_W 8

// Lock window bounds, both exclusive
`define USB_CDR_LOCK_MIN 10
`define USB_CDR_LOCK_MAX 30

// A count above this value means the line went silent
`define USB_CDR_UNLOCK_LIMIT 100

`endif
